//--- convController.sv
`timescale 1ns/100ps
`default_nettype none

module convController (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  logic sweepLast,
    output logic load,
    output logic sweepEnable,
    output logic busy,
    output logic done
);
    import convPkg::*;

    ctrlStateT state;
    ctrlStateT nextState;
    logic [$clog2(pipeDepth + 1)-1:0] flushCount;

    // ########################################
    // state register

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state      <= idle;
            flushCount <= '0;
        end else begin
            state <= nextState;
            if (state == flush) begin
                flushCount <= flushCount + 1'b1;
            end else begin
                flushCount <= '0;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (start) begin
                    nextState = run;
                end
            end
            run: begin
                if (sweepLast) begin
                    nextState = flush;
                end
            end
            flush: begin
                if (flushCount == pipeDepth - 1) begin   // last result reaches the map
                    nextState = finish;
                end
            end
            default: nextState = idle;                   // finish lasts one cycle
        endcase
    end

    // frame captured on the same edge that samples start
    assign load        = (state == idle) && start;
    assign sweepEnable = (state == run);
    assign busy        = (state != idle);
    assign done        = (state == finish);

endmodule

`default_nettype wire

//--- convLayer.sv
`timescale 1ns/100ps
`default_nettype none

module convLayer (
    input  logic               clk,
    input  logic               rstN,
    input  logic               start,
    input  convPkg::imageT     image,
    input  convPkg::kernelT    kernel,
    output logic               busy,
    output logic               done,
    output convPkg::pooledMapT pooledMap
);
    import convPkg::*;

    logic       load;
    logic       sweepEnable;
    logic       sweepLast;
    positionT   position;
    convResultT convResult;

    convController controllerInst (
        .clk         (clk),
        .rstN        (rstN),
        .start       (start),
        .sweepLast   (sweepLast),
        .load        (load),
        .sweepEnable (sweepEnable),
        .busy        (busy),
        .done        (done)
    );

    // sweep in pooling-block order
    windowCounter counterInst (
        .clk      (clk),
        .rstN     (rstN),
        .enable   (sweepEnable),
        .position (position),
        .last     (sweepLast)
    );

    windowMac macInst (
        .clk        (clk),
        .rstN       (rstN),
        .load       (load),
        .image      (image),
        .kernel     (kernel),
        .position   (position),
        .enable     (sweepEnable),
        .convResult (convResult)
    );

    maxPoolUnit poolInst (
        .clk        (clk),
        .rstN       (rstN),
        .convResult (convResult),
        .pooledMap  (pooledMap)
    );

endmodule

`default_nettype wire

//--- convLayer_sva.sv
`timescale 1ns/100ps
`default_nettype none

module convLayerSva (
    input logic clk,
    input logic rstN,
    input logic start,
    input logic busy,
    input logic done
);
    import convPkg::*;

    int failCount = 0;

    // ########################################
    // handshake rules

    doneOneCycle: assert property (@(posedge clk) disable iff (!rstN)
        done |=> !done)
        else begin
            failCount++;
            $error("done held high for more than one cycle");
        end

    doneNeedsBusy: assert property (@(posedge clk) disable iff (!rstN)
        done |-> $past(busy))
        else begin
            failCount++;
            $error("done raised without busy in the previous cycle");
        end

    // done raised runLatency edges after the edge that samples an idle start
    doneLatency: assert property (@(posedge clk) disable iff (!rstN)
        (start && !busy) |-> ##1 (!done) [*runLatency] ##1 done)
        else begin
            failCount++;
            $error("done did not follow start by runLatency edges");
        end

    resetQuiet: assert property (@(posedge clk)
        !rstN |=> (!busy && !done))
        else begin
            failCount++;
            $error("busy or done high right after reset");
        end

endmodule

bind convLayer convLayerSva convLayerSvaInst (
    .clk   (clk),
    .rstN  (rstN),
    .start (start),
    .busy  (busy),
    .done  (done)
);

`default_nettype wire

//--- convPkg.sv
`default_nettype none

package convPkg;

    // ########################################
    // sizes

    localparam int imageSize  = 10;
    localparam int kernelSize = 3;
    localparam int poolSize   = 5;
    localparam int pixelWidth = 4;
    localparam int sumWidth   = 12;
    localparam int posWidth   = $clog2(poolSize);   // 3 bits for 0..4
    localparam int pixelMax   = 2 ** (pixelWidth - 1) - 1;

    // position leaves counter -> MAC register -> pooled write
    localparam int pipeDepth  = 2;
    // start edge to done edge
    localparam int runLatency = imageSize * imageSize + pipeDepth;

    // ########################################
    // data types

    typedef logic signed [pixelWidth-1:0] pixelT;
    typedef logic signed [sumWidth-1:0]   sumT;

    typedef pixelT [imageSize-1:0][imageSize-1:0]   imageT;
    typedef pixelT [kernelSize-1:0][kernelSize-1:0] kernelT;
    typedef pixelT [poolSize-1:0][poolSize-1:0]     pooledMapT;

    typedef struct packed {
        logic [posWidth-1:0] poolRow;
        logic [posWidth-1:0] poolCol;
        logic [1:0]          sub;      // index inside the 2x2 block
    } positionT;

    typedef struct packed {
        logic     valid;
        positionT pos;
        pixelT    value;               // clipped to 0..7
    } convResultT;

    typedef enum logic [1:0] {
        idle,
        run,
        flush,
        finish
    } ctrlStateT;

endpackage

`default_nettype wire

//--- maxPoolUnit.sv
`timescale 1ns/100ps
`default_nettype none

module maxPoolUnit (
    input  logic                clk,
    input  logic                rstN,
    input  convPkg::convResultT convResult,
    output convPkg::pooledMapT  pooledMap
);
    import convPkg::*;

    pixelT runMax;
    pixelT blockMax;
    logic  blockStart;
    logic  blockEnd;

    assign blockStart = (convResult.pos.sub == 2'd0);
    assign blockEnd   = (convResult.pos.sub == 2'd3);

    // inputs are already >= 0, restart discards the old block
    always_comb begin
        if (blockStart || convResult.value > runMax) begin
            blockMax = convResult.value;
        end else begin
            blockMax = runMax;
        end
    end

    // ########################################
    // running max and map write

    always_ff @(posedge clk) begin
        if (convResult.valid) begin
            runMax <= blockMax;
        end
        if (!rstN) begin
            pooledMap <= '0;
        end else if (convResult.valid && blockEnd) begin
            pooledMap[convResult.pos.poolRow][convResult.pos.poolCol] <= blockMax;
        end
    end

endmodule

`default_nettype wire

//--- project.f
convPkg.sv
convController.sv
windowCounter.sv
windowMac.sv
maxPoolUnit.sv
convLayer.sv
convLayer_sva.sv
tbConvLayer.sv

//--- tbConvLayer.sv
`timescale 1ns/100ps
`default_nettype none

module tbConvLayer;
    import convPkg::*;

    localparam int numCases       = 6;
    localparam int satLimit       = 7;
    localparam int watchdogCycles = numCases * (runLatency + 20) + 50;

    typedef struct packed {
        logic   randomImage;
        pixelT  fillValue;     // used when the image is constant
        logic   randomKernel;
        kernelT kernel;
        logic   spuriousStart;
        logic   hasCorner;
        pixelT  cornerValue;   // known pooled value at [0][0]
    } stimCaseT;

    logic      clk;
    logic      rstN;
    logic      start;
    imageT     image;
    kernelT    kernel;
    logic      busy;
    logic      done;
    pooledMapT pooledMap;
    stimCaseT  cases [numCases];

    convLayer convLayer_inst (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .image     (image),
        .kernel    (kernel),
        .busy      (busy),
        .done      (done),
        .pooledMap (pooledMap)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: the test sequence did not finish within %0d cycles", watchdogCycles);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped by watchdog");
    end

    // ########################################
    // error reporting and compare tasks

    task automatic reportError(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    // a failed bound assertion ends the run
    initial begin
        wait (convLayer_inst.convLayerSvaInst.failCount != 0);
        reportError("a bound assertion on busy, done or latency failed");
    end

    task automatic checkMap(input pooledMapT got, input pooledMapT exp, input string what);
        if (got !== exp) begin
            reportError($sformatf("%s: got %h expected %h", what, got, exp));
        end
    endtask

    task automatic checkPixel(input pixelT got, input pixelT exp, input int row, input int col);
        if (got !== exp) begin
            reportError($sformatf("map[%0d][%0d]: got %0d expected %0d", row, col, got, exp));
        end
    endtask

    task automatic checkLatency(input int got);
        if (got != runLatency) begin
            reportError($sformatf("latency: got %0d edges expected %0d", got, runLatency));
        end
    endtask

    task automatic checkLevel(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            reportError($sformatf("%s: got %b expected %b", what, got, exp));
        end
    endtask

    // ########################################
    // reference model and stimulus helpers

    function automatic pooledMapT modelMap(input imageT img, input kernelT k);
        int        clipVal [imageSize][imageSize];
        int        sum;
        int        rr;
        int        cc;
        int        best;
        pooledMapT res;
        for (int r = 0; r < imageSize; r++) begin
            for (int c = 0; c < imageSize; c++) begin
                sum = 0;
                for (int kr = 0; kr < kernelSize; kr++) begin
                    for (int kc = 0; kc < kernelSize; kc++) begin
                        rr = r + kr - 1;
                        cc = c + kc - 1;
                        if (rr >= 0 && rr < imageSize && cc >= 0 && cc < imageSize) begin
                            sum += int'(img[rr][cc]) * int'(k[kr][kc]);
                        end
                    end
                end
                clipVal[r][c] = (sum < 0) ? 0 : ((sum > satLimit) ? satLimit : sum);
            end
        end
        for (int pr = 0; pr < poolSize; pr++) begin
            for (int pc = 0; pc < poolSize; pc++) begin
                best = 0;                          // relu output is never negative
                for (int d = 0; d < 4; d++) begin
                    if (clipVal[2 * pr + d / 2][2 * pc + d % 2] > best) begin
                        best = clipVal[2 * pr + d / 2][2 * pc + d % 2];
                    end
                end
                res[pr][pc] = pixelT'(best);
            end
        end
        return res;
    endfunction

    function automatic imageT randomImage();
        imageT img;
        for (int r = 0; r < imageSize; r++) begin
            for (int c = 0; c < imageSize; c++) begin
                img[r][c] = pixelT'($urandom_range(15, 0));
            end
        end
        return img;
    endfunction

    function automatic kernelT randomKernel();
        kernelT k;
        for (int r = 0; r < kernelSize; r++) begin
            for (int c = 0; c < kernelSize; c++) begin
                k[r][c] = pixelT'(int'($urandom_range(6, 0)) - 3);   // -3..3
            end
        end
        return k;
    endfunction

    function automatic stimCaseT makeCase(input logic rndImg, input pixelT fill,
                                          input logic rndKer, input kernelT k,
                                          input logic spurious, input logic corner,
                                          input pixelT cornerVal);
        stimCaseT tc;
        tc.randomImage   = rndImg;
        tc.fillValue     = fill;
        tc.randomKernel  = rndKer;
        tc.kernel        = k;
        tc.spuriousStart = spurious;
        tc.hasCorner     = corner;
        tc.cornerValue   = cornerVal;
        return tc;
    endfunction

    // ########################################
    // one run

    task automatic runCase(input stimCaseT tc, input int idx);
        imageT     img;
        kernelT    k;
        pooledMapT expMap;
        int        cycles;
        img = tc.randomImage ? randomImage() : {(imageSize * imageSize){tc.fillValue}};
        k   = tc.randomKernel ? randomKernel() : tc.kernel;
        expMap = modelMap(img, k);
        @(posedge clk);
        start  <= 1'b1;
        image  <= img;
        kernel <= k;
        @(posedge clk);                        // start sampled here
        start  <= 1'b0;
        image  <= randomImage();               // frame must already be captured
        kernel <= ~k;
        @(negedge clk);
        checkLevel(busy, 1'b1, "busy after start");
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            start <= tc.spuriousStart && (cycles == runLatency / 2);
            if (tc.spuriousStart && cycles == runLatency / 2) begin
                image <= randomImage();
            end
            @(negedge clk);
            checkLevel(busy, 1'b1, "busy during run");
            if (cycles > runLatency + 10) begin
                $display("Case %0d: done did not arrive within the expected time", idx);
                $display("RESULT: FAIL");
                $fatal(1, "no done pulse");
            end
        end while (!done);
        checkLatency(cycles);
        for (int r = 0; r < poolSize; r++) begin
            for (int c = 0; c < poolSize; c++) begin
                checkPixel(pooledMap[r][c], expMap[r][c], r, c);
            end
        end
        if (tc.hasCorner) begin
            checkPixel(pooledMap[0][0], tc.cornerValue, 0, 0);
        end
        repeat (3) begin
            @(posedge clk);
            image <= randomImage();
            @(negedge clk);
            checkLevel(done, 1'b0, "done after its pulse");
            checkLevel(busy, 1'b0, "busy after done");
        end
        checkMap(pooledMap, expMap, $sformatf("case %0d held map", idx));
    endtask

    // ########################################
    // main sequence

    initial begin
        rstN   = 1'b0;
        start  = 1'b0;
        image  = '0;
        kernel = '0;
        void'($urandom(50));
        cases[0] = makeCase(1'b0, 4'sd1, 1'b0, {9{4'h1}}, 1'b0, 1'b1, 4'sd7);
        cases[1] = makeCase(1'b0, 4'sd1, 1'b0, {9{4'hF}}, 1'b0, 1'b1, 4'sd0);
        cases[2] = makeCase(1'b0, 4'sd1, 1'b0, 36'h000000001, 1'b0, 1'b1, 4'sd1);
        cases[3] = makeCase(1'b1, 4'sd0, 1'b1, '0, 1'b0, 1'b0, 4'sd0);
        cases[4] = makeCase(1'b1, 4'sd0, 1'b1, '0, 1'b1, 1'b0, 4'sd0);
        cases[5] = makeCase(1'b1, 4'sd0, 1'b0, {9{4'h1}}, 1'b1, 1'b0, 4'sd0);
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkLevel(busy, 1'b0, "busy after reset");
        checkLevel(done, 1'b0, "done after reset");
        checkMap(pooledMap, '0, "map after reset");
        for (int i = 0; i < numCases; i++) begin
            runCase(cases[i], i);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- windowCounter.sv
`timescale 1ns/100ps
`default_nettype none

module windowCounter (
    input  logic              clk,
    input  logic              rstN,
    input  logic              enable,
    output convPkg::positionT position,
    output logic              last
);
    import convPkg::*;

    logic subLast;
    logic colLast;
    logic rowLast;

    assign subLast = (position.sub == 2'd3);
    assign colLast = (position.poolCol == posWidth'(poolSize - 1));
    assign rowLast = (position.poolRow == posWidth'(poolSize - 1));

    // 100th position of the sweep
    assign last = subLast && colLast && rowLast;

    // sub is the fastest digit, so each 2x2 block is contiguous
    always_ff @(posedge clk) begin
        if (!rstN) begin
            position <= '0;
        end else if (enable) begin
            if (last) begin
                position <= '0;                          // wrap for the next run
            end else if (!subLast) begin
                position.sub <= position.sub + 2'd1;
            end else begin
                position.sub <= '0;
                if (!colLast) begin
                    position.poolCol <= position.poolCol + 1'b1;
                end else begin
                    position.poolCol <= '0;
                    position.poolRow <= position.poolRow + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- windowMac.sv
`timescale 1ns/100ps
`default_nettype none

module windowMac (
    input  logic                clk,
    input  logic                rstN,
    input  logic                load,
    input  convPkg::imageT      image,
    input  convPkg::kernelT     kernel,
    input  convPkg::positionT   position,
    input  logic                enable,
    output convPkg::convResultT convResult
);
    import convPkg::*;

    imageT      imageReg;
    kernelT     kernelReg;
    logic [3:0] baseRow;
    logic [3:0] baseCol;
    sumT        windowSum;
    pixelT      clipped;

    // ########################################
    // frame capture

    always_ff @(posedge clk) begin
        if (load) begin
            imageReg  <= image;
            kernelReg <= kernel;
        end
    end

    // ########################################
    // 3x3 window, zero padded

    assign baseRow = {position.poolRow, 1'b0} + 4'(position.sub[0]);
    assign baseCol = {position.poolCol, 1'b0} + 4'(position.sub[1]);

    // kernel[kr][kc] weights pixel (row + kr - 1, col + kc - 1)
    always_comb begin
        int rowIdx;
        int colIdx;
        windowSum = '0;
        for (int kr = 0; kr < kernelSize; kr++) begin
            for (int kc = 0; kc < kernelSize; kc++) begin
                rowIdx = int'(baseRow) + kr - kernelSize / 2;
                colIdx = int'(baseCol) + kc - kernelSize / 2;
                if (rowIdx >= 0 && rowIdx < imageSize && colIdx >= 0 && colIdx < imageSize) begin
                    windowSum += sumT'(imageReg[rowIdx][colIdx]) * sumT'(kernelReg[kr][kc]);
                end
            end
        end
    end

    // relu, then saturate to the largest 4-bit value
    always_comb begin
        if (windowSum < 0) begin
            clipped = '0;
        end else if (windowSum > sumT'(pixelMax)) begin
            clipped = pixelT'(pixelMax);
        end else begin
            clipped = pixelT'(windowSum);
        end
    end

    // ########################################
    // output register

    always_ff @(posedge clk) begin
        convResult.pos   <= position;
        convResult.value <= clipped;
        if (!rstN) begin
            convResult.valid <= 1'b0;
        end else begin
            convResult.valid <= enable;                  // sweepEnable delayed by one
        end
    end

endmodule

`default_nettype wire
